/* Makefile */
# Verilator build and run of the memory game testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, pass is found in sim.log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module memoryGameTb -Mdir obj_dir -o memoryGameSim
	./obj_dir/memoryGameSim | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* gameControl.sv */
// Memory game control unit, a Moore FSM that runs one round and flags its result
module gameControl (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   start,
    gameDatapathIf.control         bus,
    output logic                   done,
    output logic                   won,
    output logic                   lost,
    output logic                   timedOut,
    output memoryGamePkg::gameState debugState
);

    memoryGamePkg::gameState state;
    memoryGamePkg::gameState nextState;

    // --------------------
    // State register
    // --------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= memoryGamePkg::idle;
        end else begin
            state <= nextState;
        end
    end

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        case (state)
            memoryGamePkg::idle: begin
                nextState = start ? memoryGamePkg::prepare : memoryGamePkg::idle;
            end
            // Always one cycle to clear the datapath
            memoryGamePkg::prepare: begin
                nextState = memoryGamePkg::waitPlay;
            end
            // Timeout wins over a press in the same cycle
            memoryGamePkg::waitPlay: begin
                if (bus.timeout) begin
                    nextState = memoryGamePkg::endTimeout;
                end else if (bus.playSeen) begin
                    nextState = memoryGamePkg::storePlay;
                end else begin
                    nextState = memoryGamePkg::waitPlay;
                end
            end
            memoryGamePkg::storePlay: begin
                nextState = memoryGamePkg::compare;
            end
            // Verdict on the stored press
            memoryGamePkg::compare: begin
                if (!bus.match) begin
                    nextState = memoryGamePkg::endLost;
                end else if (bus.lastMove) begin
                    nextState = memoryGamePkg::endWon;
                end else begin
                    nextState = memoryGamePkg::nextMove;
                end
            end
            memoryGamePkg::nextMove: begin
                nextState = memoryGamePkg::waitPlay;
            end
            // End states hold until a new start
            memoryGamePkg::endWon,
            memoryGamePkg::endLost,
            memoryGamePkg::endTimeout: begin
                nextState = start ? memoryGamePkg::prepare : state;
            end
            default: begin
                nextState = memoryGamePkg::idle;
            end
        endcase
    end

    // --------------------
    // Moore outputs
    // --------------------
    always_comb begin
        // Address back to the first move before each round
        bus.clearAddress   = (state == memoryGamePkg::idle) || (state == memoryGamePkg::prepare);
        bus.clearPlay      = (state == memoryGamePkg::idle) || (state == memoryGamePkg::prepare);
        bus.storePlay      = (state == memoryGamePkg::storePlay);
        bus.advanceAddress = (state == memoryGamePkg::nextMove);
        // Timer runs only here
        bus.waiting        = (state == memoryGamePkg::waitPlay);

        done     = (state == memoryGamePkg::endWon) || (state == memoryGamePkg::endLost)
                   || (state == memoryGamePkg::endTimeout);
        won      = (state == memoryGamePkg::endWon);
        // Timeout counts as a loss too
        lost     = (state == memoryGamePkg::endLost) || (state == memoryGamePkg::endTimeout);
        timedOut = (state == memoryGamePkg::endTimeout);
    end

    // State code shown as is
    assign debugState = state;

endmodule

/* gameDatapathIf.sv */
// Memory game link between the control unit and the datapath blocks
interface gameDatapathIf (
    input logic clock
);

    // Strobes from the control unit
    logic clearAddress;
    logic advanceAddress;
    logic clearPlay;
    logic storePlay;
    logic waiting;

    // Datapath status
    logic                                lastMove;
    logic [memoryGamePkg::moveWidth-1:0] expectedMove;
    logic                                playSeen;
    logic                                match;
    logic                                timeout;

    // --------------------
    // Views per block
    // --------------------
    modport control (
        input  clock, lastMove, playSeen, match, timeout,
        output clearAddress, advanceAddress, clearPlay, storePlay, waiting
    );
    modport sequencer (input clock, clearAddress, advanceAddress, output lastMove, expectedMove);
    modport capture (input clock, clearPlay, storePlay, expectedMove, output playSeen, match);
    modport timer (input clock, waiting, output timeout);

endinterface

/* memoryGame.sv */
// Memory game top level joining the control unit and the datapath blocks
module memoryGame (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   start,
    input  logic [memoryGamePkg::moveWidth-1:0]    buttons,
    output logic                                   done,
    output logic                                   won,
    output logic                                   lost,
    output logic                                   timedOut,
    output memoryGamePkg::gameState                debugState,
    output logic [memoryGamePkg::addressWidth-1:0] address
);

    // Shared strobes and status
    gameDatapathIf bus (
        .clock(clock)
    );

    // --------------------
    // Control unit
    // --------------------
    gameControl control (
        .clock     (clock),
        .reset     (reset),
        .start     (start),
        .bus       (bus),
        .done      (done),
        .won       (won),
        .lost      (lost),
        .timedOut  (timedOut),
        .debugState(debugState)
    );

    // --------------------
    // Datapath
    // --------------------
    sequenceMemory sequencer (
        .clock  (clock),
        .reset  (reset),
        .bus    (bus),
        .address(address)
    );

    // Press detect and compare
    playCapture capture (
        .clock  (clock),
        .reset  (reset),
        .buttons(buttons),
        .bus    (bus)
    );

    moveTimer timer (
        .clock(clock),
        .reset(reset),
        .bus  (bus)
    );

endmodule

/* memoryGamePkg.sv */
// Memory game package with sizes, the fixed move table, the timeout limit and the FSM states
package memoryGamePkg;

    // --------------------
    // Sizes
    // --------------------

    // One bit per button
    localparam int moveWidth = 4;
    // Moves in a full round
    localparam int sequenceLength = 16;
    localparam int addressWidth = 4;
    // Address of the final move
    localparam logic [addressWidth-1:0] lastAddress = addressWidth'(sequenceLength - 1);

    // --------------------
    // Move table
    // --------------------

    // Fixed sequence of one-hot moves, entry 0 played first
    localparam logic [moveWidth-1:0] moveTable [sequenceLength] = '{
        4'b0001, 4'b0010, 4'b0100, 4'b1000,
        4'b0100, 4'b0010, 4'b0001, 4'b0001,
        4'b1000, 4'b0100, 4'b1000, 4'b0010,
        4'b0001, 4'b0100, 4'b0010, 4'b1000
    };

    // --------------------
    // Timeout
    // --------------------

    localparam int timerWidth = 8;
    // Short limit keeps simulation fast
    localparam logic [timerWidth-1:0] moveTimeoutCycles = 8'd200;

    // Control states, values double as the debug display code
    typedef enum logic [3:0] {
        idle       = 4'h0,
        prepare    = 4'h1,
        waitPlay   = 4'h3,
        storePlay  = 4'h4,
        compare    = 4'h5,
        nextMove   = 4'h6,
        endWon     = 4'hA,
        endTimeout = 4'hD,
        endLost    = 4'hE
    } gameState;

endpackage

/* memoryGameTb.sv */
// Memory game testbench with directed rounds for win, wrong press, timeout and restart
module memoryGameTb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                                   clock;
    logic                                   reset;
    logic                                   start;
    logic [memoryGamePkg::moveWidth-1:0]    buttons;
    logic                                   done;
    logic                                   won;
    logic                                   lost;
    logic                                   timedOut;
    memoryGamePkg::gameState                debugState;
    logic [memoryGamePkg::addressWidth-1:0] address;

    int          errorCount;
    int unsigned rngState;

    memoryGame dut (
        .clock     (clock),
        .reset     (reset),
        .start     (start),
        .buttons   (buttons),
        .done      (done),
        .won       (won),
        .lost      (lost),
        .timedOut  (timedOut),
        .debugState(debugState),
        .address   (address)
    );

    // 40 ns period
    always #20 clock = ~clock;

    // Tests run at most about 550 cycles or 22 us, well inside 80 us
    initial begin
        #80us;
        $display("Simulation hung, watchdog stopped the run");
        $display("Checks failed");
        $finish;
    end

    // --------------------
    // Checks
    // --------------------
    task automatic checkState(string what, memoryGamePkg::gameState actual,
                              memoryGamePkg::gameState expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s is %s, expected %s", $time, what, actual.name(),
                     expected.name());
            errorCount++;
        end
    endtask

    task automatic checkFlag(string what, logic actual, logic expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, actual, expected);
            errorCount++;
        end
    endtask

    task automatic checkAddress(string what, logic [memoryGamePkg::addressWidth-1:0] actual,
                                logic [memoryGamePkg::addressWidth-1:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
            errorCount++;
        end
    endtask

    // LCG step returning the better upper bits
    function automatic int unsigned nextRandom();
        rngState = rngState * 32'd1103515245 + 32'd12345;
        return rngState >> 16;
    endfunction

    // --------------------
    // Stimulus helpers
    // --------------------

    // Start pulse then waitPlay two cycles later with a cleared datapath
    task automatic beginRound();
        @(negedge clock) start = 1'b1;
        @(negedge clock) start = 1'b0;
        @(negedge clock);
        checkState("state after start", debugState, memoryGamePkg::waitPlay);
        checkAddress("address after start", address, '0);
        checkFlag("done after start", done, 1'b0);
        checkFlag("won after start", won, 1'b0);
        checkFlag("lost after start", lost, 1'b0);
        checkFlag("timedOut after start", timedOut, 1'b0);
    endtask

    // Hold three cycles, release three, then settle
    task automatic pressMove(logic [memoryGamePkg::moveWidth-1:0] move);
        int waitCycles;
        @(negedge clock) buttons = move;
        repeat (3) @(negedge clock);
        buttons = '0;
        repeat (3) @(negedge clock);
        waitCycles = 0;
        while (!done && debugState != memoryGamePkg::waitPlay && waitCycles < 20) begin
            @(negedge clock);
            waitCycles++;
        end
        if (!done && debugState != memoryGamePkg::waitPlay) begin
            $display("DUT neither finished nor returned to waitPlay after a press");
            errorCount++;
        end
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic resetTest();
        checkState("state after reset", debugState, memoryGamePkg::idle);
        checkFlag("done after reset", done, 1'b0);
        checkFlag("won after reset", won, 1'b0);
        checkFlag("lost after reset", lost, 1'b0);
        checkAddress("address after reset", address, '0);
    endtask

    task automatic winningRound();
        for (int i = 0; i < memoryGamePkg::sequenceLength; i++) begin
            pressMove(memoryGamePkg::moveTable[i]);
            if (i < memoryGamePkg::sequenceLength - 1) begin
                checkAddress("address after move", address,
                             memoryGamePkg::addressWidth'(i + 1));
                checkFlag("done during round", done, 1'b0);
            end
        end
        checkFlag("done after win", done, 1'b1);
        checkFlag("won after win", won, 1'b1);
        checkFlag("lost after win", lost, 1'b0);
        checkState("state after win", debugState, memoryGamePkg::endWon);
        checkAddress("address after win", address,
                     memoryGamePkg::addressWidth'(memoryGamePkg::sequenceLength - 1));
    endtask

    task automatic wrongPressRound();
        int position;
        int buttonIndex;
        logic [memoryGamePkg::moveWidth-1:0] wrongMove;
        position = nextRandom() % memoryGamePkg::sequenceLength;
        buttonIndex = nextRandom() % memoryGamePkg::moveWidth;
        wrongMove = 1 << buttonIndex;
        // Step to the next button if the pick was right
        if (wrongMove == memoryGamePkg::moveTable[position]) begin
            wrongMove = 1 << ((buttonIndex + 1) % memoryGamePkg::moveWidth);
        end
        for (int i = 0; i < position; i++) begin
            pressMove(memoryGamePkg::moveTable[i]);
        end
        pressMove(wrongMove);
        checkFlag("done after wrong press", done, 1'b1);
        checkFlag("lost after wrong press", lost, 1'b1);
        checkFlag("won after wrong press", won, 1'b0);
        checkFlag("timedOut after wrong press", timedOut, 1'b0);
        checkState("state after wrong press", debugState, memoryGamePkg::endLost);
        checkAddress("address after wrong press", address,
                     memoryGamePkg::addressWidth'(position));
    endtask

    // Counted from the first waitPlay cycle
    task automatic timeoutRound();
        int cycles;
        cycles = 0;
        while (!done && cycles < int'(memoryGamePkg::moveTimeoutCycles) + 20) begin
            @(negedge clock);
            cycles++;
        end
        checkFlag("timeout after exactly the limit",
                  cycles == int'(memoryGamePkg::moveTimeoutCycles), 1'b1);
        checkFlag("timedOut after timeout", timedOut, 1'b1);
        checkFlag("lost after timeout", lost, 1'b1);
        checkFlag("won after timeout", won, 1'b0);
        checkState("state after timeout", debugState, memoryGamePkg::endTimeout);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        clock = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        buttons = '0;
        errorCount = 0;
        rngState = 10516;
        repeat (3) @(negedge clock);
        reset = 1'b0;
        resetTest();
        beginRound();
        winningRound();
        // Each start below is a restart from an end state
        beginRound();
        wrongPressRound();
        beginRound();
        timeoutRound();
        beginRound();
        winningRound();
        $display("Errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* memoryGame_assert.sv */
// Memory game control checks on the result flags, restart and address strobes
module gameControlAssert (
    input logic                    clock,
    input logic                    reset,
    input logic                    start,
    input logic                    done,
    input logic                    won,
    input logic                    lost,
    input logic                    timedOut,
    input memoryGamePkg::gameState state,
    input logic                    clearAddress,
    input logic                    advanceAddress
);
    timeunit 1ns;
    timeprecision 1ps;

    // --------------------
    // Result flags
    // --------------------
    resultExclusive: assert property (@(posedge clock) disable iff (reset) !(won && lost))
        else $error("won and lost high together");

    // Timeout is reported as a loss
    timeoutIsLoss: assert property (@(posedge clock) disable iff (reset) timedOut |-> lost)
        else $error("timedOut without lost");

    // End state left only through prepare
    restartFromEnd: assert property (@(posedge clock) disable iff (reset)
        (done && start) |=> (state == memoryGamePkg::prepare))
        else $error("start in an end state did not reach prepare");

    // --------------------
    // Address strobes
    // --------------------
    addressStrobes: assert property (@(posedge clock) disable iff (reset)
        !(advanceAddress && clearAddress))
        else $error("advanceAddress and clearAddress high together");

endmodule

bind gameControl gameControlAssert controlChecks (
    .clock         (clock),
    .reset         (reset),
    .start         (start),
    .done          (done),
    .won           (won),
    .lost          (lost),
    .timedOut      (timedOut),
    .state         (state),
    .clearAddress  (bus.clearAddress),
    .advanceAddress(bus.advanceAddress)
);

/* moveTimer.sv */
// Memory game move timer that counts waiting cycles and flags the timeout
module moveTimer (
    input  logic         clock,
    input  logic         reset,
    gameDatapathIf.timer bus
);

    // Cycles spent in the current wait
    logic [memoryGamePkg::timerWidth-1:0] count;

    // --------------------
    // Wait counter
    // --------------------

    // Restarts on every cycle outside the wait
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (!bus.waiting) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // One cycle early so the end state lands on the limit
    assign bus.timeout = (count == memoryGamePkg::moveTimeoutCycles - 1'b1);

endmodule

/* playCapture.sv */
// Memory game press capture with button sync, new press detect, play register and compare
module playCapture (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [memoryGamePkg::moveWidth-1:0] buttons,
    gameDatapathIf.capture                      bus
);

    // Sampled buttons and their previous sample
    logic [memoryGamePkg::moveWidth-1:0] buttonsSync;
    logic [memoryGamePkg::moveWidth-1:0] buttonsLast;
    // Stored press for the compare
    logic [memoryGamePkg::moveWidth-1:0] play;

    // --------------------
    // Button sampling
    // --------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            buttonsSync <= '0;
            buttonsLast <= '0;
        end else begin
            buttonsSync <= buttons;
            buttonsLast <= buttonsSync;
        end
    end

    // New press only from all buttons released
    assign bus.playSeen = (|buttonsSync) && !(|buttonsLast);

    // --------------------
    // Play register
    // --------------------

    // Loads the press still held during storePlay
    always_ff @(posedge clock) begin
        if (bus.clearPlay) begin
            play <= '0;
        end else if (bus.storePlay) begin
            play <= buttonsSync;
        end
    end

    // Exact match against the table entry
    assign bus.match = (play == bus.expectedMove);

endmodule

/* sequenceMemory.sv */
// Memory game move sequencer with the address counter, table lookup and last move flag
module sequenceMemory (
    input  logic                                  clock,
    input  logic                                  reset,
    gameDatapathIf.sequencer                      bus,
    output logic [memoryGamePkg::addressWidth-1:0] address
);

    // Current move index
    logic [memoryGamePkg::addressWidth-1:0] moveIndex;

    // --------------------
    // Address counter
    // --------------------

    // Clear has priority over advance
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            moveIndex <= '0;
        end else if (bus.clearAddress) begin
            moveIndex <= '0;
        end else if (bus.advanceAddress) begin
            moveIndex <= moveIndex + 1'b1;
        end
    end

    // --------------------
    // Table lookup
    // --------------------

    // Move expected at this index
    assign bus.expectedMove = memoryGamePkg::moveTable[moveIndex];

    // High while on the final entry
    assign bus.lastMove = (moveIndex == memoryGamePkg::lastAddress);

    // Index for display
    assign address = moveIndex;

endmodule

/* sim.f */
memoryGamePkg.sv
gameDatapathIf.sv
gameControl.sv
sequenceMemory.sv
playCapture.sv
moveTimer.sv
memoryGame.sv
memoryGame_assert.sv
memoryGameTb.sv
